// ==== arcade_wrapper.f ====
src/arcade_pkg.sv
src/ps2_keyboard.sv
src/video_timing.sv
src/game_core.sv
src/video_mixer.sv
src/sigma_delta_dac.sv
src/arcade_wrapper.sv
tests/tb_arcade_wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	-f arcade_wrapper.f --top-module tb_arcade_wrapper -o tb_arcade_wrapper

./obj_dir/tb_arcade_wrapper > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported errors"
	exit 1
fi
grep -q "Test OK" sim.log

// ==== src/arcade_pkg.sv ====
package arcade_pkg;

	localparam int CNT_W = 10; // Width of the raster counters

	typedef enum logic [1:0] {
		GAME_ATTRACT,
		GAME_PLAY
	} game_state_t;

	typedef enum logic [1:0] {
		PS2_IDLE,
		PS2_DATA,
		PS2_PARITY,
		PS2_STOP
	} ps2_state_t;

	typedef enum logic [1:0] {
		SCAN_NONE,
		SCAN_25,
		SCAN_50
	} scan_mode_t;

	// Bit positions in the keys vector
	localparam int KEY_LEFT  = 0;
	localparam int KEY_RIGHT = 1;
	localparam int KEY_GAS   = 2;
	localparam int KEY_START = 3;

	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_GAS    = 8'h29; // Space bar
	localparam logic [7:0] SC_START  = 8'h16; // Key 1
	localparam logic [7:0] SC_BREAK  = 8'hF0;
	localparam logic [7:0] SC_EXTEND = 8'hE0;

	localparam logic [6:0] ENGINE_IDLE = 7'd32;
	localparam logic [6:0] ENGINE_GAS  = 7'd96;

	localparam int CAR_W = 8;
	localparam int CAR_H = 4;
	localparam int CAR_Y = 20;

endpackage

// ==== src/arcade_wrapper.sv ====
module arcade_wrapper import arcade_pkg::*; #(
	parameter int H_ACTIVE = 256,
	parameter int H_FP     = 16,
	parameter int H_SYNC   = 24,
	parameter int H_TOTAL  = 320,
	parameter int V_ACTIVE = 224,
	parameter int V_FP     = 8,
	parameter int V_SYNC   = 4,
	parameter int V_TOTAL  = 256
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       ps2_kbd_clk,
	input  logic       ps2_kbd_data,
	input  scan_mode_t scan_mode,
	input  logic       test_mode,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       audio_l,
	output logic       audio_r,
	output logic       led
);

	logic [3:0]       keys;
	logic [CNT_W-1:0] hcount;
	logic [CNT_W-1:0] vcount;
	logic             hs, vs, hb, vb;
	logic             frame_start;
	logic             video;
	logic             line_odd;
	logic             hs_q, vs_q, blank_q;
	logic [6:0]       level;

	ps2_keyboard keyboard (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.keys         (keys)
	);

	video_timing #(
		.H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_TOTAL (H_TOTAL),
		.V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_TOTAL (V_TOTAL)
	) timing (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.ce_pix      (),
		.hcount      (hcount),
		.vcount      (vcount),
		.hs          (hs),
		.vs          (vs),
		.hb          (hb),
		.vb          (vb),
		.frame_start (frame_start)
	);

	game_core #(.H_ACTIVE (H_ACTIVE), .V_ACTIVE (V_ACTIVE)) core (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.keys        (keys),
		.test_mode   (test_mode),
		.hcount      (hcount),
		.vcount      (vcount),
		.hs          (hs),
		.vs          (vs),
		.hb          (hb),
		.vb          (vb),
		.frame_start (frame_start),
		.video       (video),
		.line_odd    (line_odd),
		.hs_q        (hs_q),
		.vs_q        (vs_q),
		.blank_q     (blank_q),
		.led         (led),
		.level       (level)
	);

	video_mixer mixer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.video     (video),
		.line_odd  (line_odd),
		.hs_q      (hs_q),
		.vs_q      (vs_q),
		.blank_q   (blank_q),
		.scan_mode (scan_mode),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac dac_l (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.level   (level),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l; // Mono sound on both channels

endmodule

// ==== src/game_core.sv ====
module game_core import arcade_pkg::*; #(
	parameter int H_ACTIVE = 256,
	parameter int V_ACTIVE = 224
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [3:0]       keys,
	input  logic             test_mode,
	input  logic [CNT_W-1:0] hcount,
	input  logic [CNT_W-1:0] vcount,
	input  logic             hs,
	input  logic             vs,
	input  logic             hb,
	input  logic             vb,
	input  logic             frame_start,
	output logic             video,
	output logic             line_odd,
	output logic             hs_q,
	output logic             vs_q,
	output logic             blank_q,
	output logic             led,
	output logic [6:0]       level
);

	localparam logic [CNT_W-1:0] X_MIN  = CNT_W'(1);
	localparam logic [CNT_W-1:0] X_MAX  = CNT_W'(H_ACTIVE - CAR_W - 1);
	localparam logic [CNT_W-1:0] X_LAST = CNT_W'(H_ACTIVE - 1);
	localparam logic [CNT_W-1:0] Y_LAST = CNT_W'(V_ACTIVE - 1);
	localparam logic [CNT_W-1:0] Y_TOP  = CNT_W'(CAR_Y);
	localparam logic [CNT_W-1:0] Y_BOT  = CNT_W'(CAR_Y + CAR_H);

	game_state_t      state;
	logic             start_seen; // Start key held at least once
	logic [CNT_W-1:0] car_x;
	logic             border;
	logic             car;
	logic             pixel;

	assign border = (hcount == '0) || (hcount == X_LAST) || (vcount == '0) || (vcount == Y_LAST);
	assign car    = (hcount >= car_x) && (hcount < car_x + CNT_W'(CAR_W)) &&
	                (vcount >= Y_TOP) && (vcount < Y_BOT);
	assign pixel  = test_mode ? (hcount[3] ^ vcount[3]) : (border | car);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= GAME_ATTRACT;
			start_seen <= 1'b0;
			car_x      <= CNT_W'(H_ACTIVE / 2);
			led        <= 1'b1;
			level      <= '0;
		end else begin
			start_seen <= start_seen | keys[KEY_START];
			led        <= ~(start_seen | keys[KEY_START]); // Start lamp lit in attract
			if (state == GAME_PLAY)
				level <= keys[KEY_GAS] ? ENGINE_GAS : ENGINE_IDLE;
			else
				level <= '0;
			if (frame_start) begin
				if (state == GAME_ATTRACT && start_seen)
					state <= GAME_PLAY;
				if (state == GAME_PLAY) begin
					if (keys[KEY_RIGHT] && car_x < X_MAX)
						car_x <= car_x + 1'b1;
					else if (keys[KEY_LEFT] && car_x > X_MIN)
						car_x <= car_x - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			video    <= 1'b0;
			line_odd <= 1'b0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			blank_q  <= 1'b1;
		end else begin
			video    <= pixel;
			line_odd <= vcount[0];
			hs_q     <= hs;
			vs_q     <= vs;
			blank_q  <= hb | vb;
		end
	end

endmodule

// ==== src/ps2_keyboard.sv ====
module ps2_keyboard import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       ps2_kbd_clk,
	input  logic       ps2_kbd_data,
	output logic [3:0] keys
);

	logic [2:0] clk_sr; // Two sync stages plus the previous value
	logic [1:0] data_sr;
	logic       fall;
	logic       bit_in;

	ps2_state_t state;
	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic       parity_ok;
	logic       release_flag; // Set by a break prefix

	assign fall   = clk_sr[2] & ~clk_sr[1];
	assign bit_in = data_sr[1];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clk_sr  <= '1;
			data_sr <= '1;
		end else begin
			clk_sr  <= {clk_sr[1:0], ps2_kbd_clk};
			data_sr <= {data_sr[0], ps2_kbd_data};
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state        <= PS2_IDLE;
			shift        <= '0;
			bit_cnt      <= '0;
			parity_ok    <= 1'b0;
			release_flag <= 1'b0;
			keys         <= '0;
		end else if (fall) begin
			case (state)
				PS2_IDLE: begin
					if (!bit_in) begin // Start bit
						state   <= PS2_DATA;
						bit_cnt <= '0;
					end
				end
				PS2_DATA: begin
					shift   <= {bit_in, shift[7:1]}; // LSB first
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= PS2_PARITY;
				end
				PS2_PARITY: begin
					parity_ok <= ^{shift, bit_in}; // Odd parity
					state     <= PS2_STOP;
				end
				PS2_STOP: begin
					state <= PS2_IDLE;
					if (bit_in && parity_ok) begin
						if (shift == SC_BREAK) begin
							release_flag <= 1'b1;
						end else if (shift != SC_EXTEND) begin
							release_flag <= 1'b0;
							case (shift)
								SC_LEFT:  keys[KEY_LEFT]  <= ~release_flag;
								SC_RIGHT: keys[KEY_RIGHT] <= ~release_flag;
								SC_GAS:   keys[KEY_GAS]   <= ~release_flag;
								SC_START: keys[KEY_START] <= ~release_flag;
								default:  ;
							endcase
						end
					end
				end
				default: state <= PS2_IDLE;
			endcase
		end
	end

endmodule

// ==== src/sigma_delta_dac.sv ====
module sigma_delta_dac (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [6:0] level,
	output logic       dac_out
);

	logic [6:0] acc;
	logic [7:0] sum;

	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[6:0];
			dac_out <= sum[7]; // Carry is the pulse density output
		end
	end

endmodule

// ==== src/video_mixer.sv ====
module video_mixer import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       video,
	input  logic       line_odd,
	input  logic       hs_q,
	input  logic       vs_q,
	input  logic       blank_q,
	input  scan_mode_t scan_mode,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	localparam logic [5:0] FULL = 6'd63;

	logic [5:0] lum;

	always_comb begin
		lum = '0;
		if (video && !blank_q) begin
			lum = FULL;
			if (line_odd) begin
				case (scan_mode)
					SCAN_25: lum = FULL - (FULL >> 2); // Quarter darker
					SCAN_50: lum = FULL >> 1;
					default: lum = FULL;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= lum;
			vga_g  <= lum;
			vga_b  <= lum;
			vga_hs <= hs_q;
			vga_vs <= vs_q;
		end
	end

endmodule

// ==== src/video_timing.sv ====
module video_timing import arcade_pkg::*; #(
	parameter int H_ACTIVE = 256,
	parameter int H_FP     = 16,
	parameter int H_SYNC   = 24,
	parameter int H_TOTAL  = 320,
	parameter int V_ACTIVE = 224,
	parameter int V_FP     = 8,
	parameter int V_SYNC   = 4,
	parameter int V_TOTAL  = 256
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	output logic             ce_pix,
	output logic [CNT_W-1:0] hcount,
	output logic [CNT_W-1:0] vcount,
	output logic             hs,
	output logic             vs,
	output logic             hb,
	output logic             vb,
	output logic             frame_start
);

	localparam logic [CNT_W-1:0] H_LAST   = CNT_W'(H_TOTAL - 1);
	localparam logic [CNT_W-1:0] V_LAST   = CNT_W'(V_TOTAL - 1);
	localparam logic [CNT_W-1:0] HS_BEG   = CNT_W'(H_ACTIVE + H_FP);
	localparam logic [CNT_W-1:0] HS_END   = CNT_W'(H_ACTIVE + H_FP + H_SYNC);
	localparam logic [CNT_W-1:0] VS_BEG   = CNT_W'(V_ACTIVE + V_FP);
	localparam logic [CNT_W-1:0] VS_END   = CNT_W'(V_ACTIVE + V_FP + V_SYNC);
	localparam logic [CNT_W-1:0] H_ACT    = CNT_W'(H_ACTIVE);
	localparam logic [CNT_W-1:0] V_ACT    = CNT_W'(V_ACTIVE);
	localparam logic [CNT_W-1:0] V_ACT_M1 = CNT_W'(V_ACTIVE - 1);

	logic [1:0]       div;
	logic [CNT_W-1:0] h_next;
	logic [CNT_W-1:0] v_next;

	always_comb begin
		h_next = (hcount == H_LAST) ? '0 : hcount + 1'b1;
		v_next = vcount;
		if (hcount == H_LAST)
			v_next = (vcount == V_LAST) ? '0 : vcount + 1'b1;
	end

	// Flags decode the next counter values so they change together with the counters
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div         <= '0;
			ce_pix      <= 1'b0;
			hcount      <= '0;
			vcount      <= '0;
			hs          <= 1'b0;
			vs          <= 1'b0;
			hb          <= 1'b0;
			vb          <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			div         <= div + 2'd1;
			ce_pix      <= (div == 2'd3); // One pixel every four clocks
			frame_start <= ce_pix && (hcount == H_LAST) && (vcount == V_ACT_M1);
			if (ce_pix) begin
				hcount <= h_next;
				vcount <= v_next;
				hs     <= (h_next >= HS_BEG) && (h_next < HS_END);
				vs     <= (v_next >= VS_BEG) && (v_next < VS_END);
				hb     <= (h_next >= H_ACT);
				vb     <= (v_next >= V_ACT);
			end
		end
	end

endmodule

// ==== tests/tb_arcade_wrapper.sv ====
module tb_arcade_wrapper import arcade_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int H_ACTIVE = 64;
	localparam int H_FP     = 4;
	localparam int H_SYNC   = 4;
	localparam int H_TOTAL  = 80;
	localparam int V_ACTIVE = 48;
	localparam int V_FP     = 2;
	localparam int V_SYNC   = 2;
	localparam int V_TOTAL  = 56;
	localparam int FRAME_CYCLES = 4 * H_TOTAL * V_TOTAL;
	localparam int PS2_HALF     = 20; // Half of the PS/2 bit period

	logic       clk_sys = 1'b0;
	logic       rst_n;
	logic       ps2_kbd_clk;
	logic       ps2_kbd_data;
	scan_mode_t scan_mode;
	logic       test_mode;
	logic [5:0] vga_r;
	logic [5:0] vga_g;
	logic [5:0] vga_b;
	logic       vga_hs;
	logic       vga_vs;
	logic       audio_l;
	logic       audio_r;
	logic       led;

	int seed = 83933;
	int error_count = 0;
	int exp_car_x = H_ACTIVE / 2;

	int   mon_x = 0;
	int   mon_y = 0;
	int   mon_phase = 0; // Clock cycle inside the current pixel
	logic synced = 1'b0;
	logic hs_prev = 1'b0;
	logic vs_prev = 1'b0;
	int   hs_cnt = 0;
	int   hs_per_frame = 0;
	logic frame_on = 1'b0;
	int   frames_done = 0;
	int   frames_wanted = 0;

	arcade_wrapper #(
		.H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_TOTAL (H_TOTAL),
		.V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_TOTAL (V_TOTAL)
	) arcade_wrapper_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.scan_mode    (scan_mode),
		.test_mode    (test_mode),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.led          (led)
	);

	always #5 clk_sys = ~clk_sys;

	task automatic abort_run(input string why);
		error_count++;
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_color(input string name, input logic [5:0] got, input logic [5:0] want);
		if (got !== want)
			abort_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, want));
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
			abort_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, want));
	endtask

	task automatic check_level(input string name, input logic [6:0] got, input logic [6:0] want);
		if (got !== want)
			abort_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, want));
	endtask

	function automatic logic [5:0] ref_color(input int x, input int y, input int car_x,
		input logic tmode, input scan_mode_t smode);
		logic lit;
		if (x >= H_ACTIVE || y >= V_ACTIVE)
			return 6'd0;
		if (tmode)
			lit = ((x / 8) % 2) != ((y / 8) % 2); // Checkerboard of 8x8 cells
		else
			lit = x == 0 || x == H_ACTIVE - 1 || y == 0 || y == V_ACTIVE - 1 ||
			      (x >= car_x && x < car_x + CAR_W && y >= CAR_Y && y < CAR_Y + CAR_H);
		if (!lit)
			return 6'd0;
		if (y % 2 == 1 && smode == SCAN_25)
			return 6'd48;
		if (y % 2 == 1 && smode == SCAN_50)
			return 6'd31;
		return 6'd63;
	endfunction

	// Raster monitor, pixels are sampled in their third cycle
	always @(negedge clk_sys) begin
		logic [5:0] want;
		if (!rst_n) begin
			synced   = 1'b0;
			frame_on = 1'b0;
		end else begin
			if (synced) begin
				if (mon_phase == 3) begin
					mon_phase = 0;
					if (mon_x == H_TOTAL - 1) begin
						mon_x = 0;
						mon_y = (mon_y == V_TOTAL - 1) ? 0 : mon_y + 1;
					end else begin
						mon_x++;
					end
				end else begin
					mon_phase++;
				end
			end
			if (vga_hs && !hs_prev) begin
				mon_x     = H_ACTIVE + H_FP;
				mon_phase = 0;
				hs_cnt++;
			end
			if (vga_vs && !vs_prev) begin
				synced       = 1'b1;
				mon_x        = 0;
				mon_y        = V_ACTIVE + V_FP;
				mon_phase    = 0;
				hs_per_frame = hs_cnt;
				hs_cnt       = 0;
			end
			if (synced && !frame_on && frames_done < frames_wanted &&
			    mon_x == 0 && mon_y == 0 && mon_phase == 0)
				frame_on = 1'b1;
			if (frame_on && mon_phase == 2) begin
				want = ref_color(mon_x, mon_y, exp_car_x, test_mode, scan_mode);
				check_color($sformatf("vga_r (%0d,%0d)", mon_x, mon_y), vga_r, want);
				check_color($sformatf("vga_g (%0d,%0d)", mon_x, mon_y), vga_g, want);
				check_color($sformatf("vga_b (%0d,%0d)", mon_x, mon_y), vga_b, want);
				check_bit("vga_hs", vga_hs,
					mon_x >= H_ACTIVE + H_FP && mon_x < H_ACTIVE + H_FP + H_SYNC);
				check_bit("vga_vs", vga_vs,
					mon_y >= V_ACTIVE + V_FP && mon_y < V_ACTIVE + V_FP + V_SYNC);
			end
			if (frame_on && mon_phase == 3 && mon_x == H_TOTAL - 1 && mon_y == V_TOTAL - 1) begin
				frame_on = 1'b0;
				frames_done++;
			end
		end
		hs_prev = vga_hs;
		vs_prev = vga_vs;
	end

	task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~^code ^ bad_parity, code, 1'b0}; // Stop, odd parity, data, start
		for (int i = 0; i < 11; i++) begin
			ps2_kbd_data = bits[i];
			repeat (PS2_HALF) @(negedge clk_sys);
			ps2_kbd_clk = 1'b0;
			repeat (PS2_HALF) @(negedge clk_sys);
			ps2_kbd_clk = 1'b1;
		end
		repeat (PS2_HALF) @(negedge clk_sys);
	endtask

	task automatic wait_vs_rise();
		logic prev;
		logic rise;
		int   waited;
		prev   = vga_vs;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
			if (waited > 2 * FRAME_CYCLES)
				abort_run("Timed out waiting for a rising edge on vga_vs");
			rise = vga_vs && !prev;
			prev = vga_vs;
		end while (!rise);
	endtask

	task automatic check_frame();
		int waited;
		wait_vs_rise();
		frames_wanted = frames_done + 1;
		waited = 0;
		while (frames_done < frames_wanted) begin
			@(negedge clk_sys);
			waited++;
			if (waited > 2 * FRAME_CYCLES)
				abort_run("Timed out waiting for a full frame to be checked");
		end
	endtask

	// A constant level gives exactly that many ones in 128 cycles
	task automatic check_audio(input logic [6:0] want);
		int ones_l;
		int ones_r;
		ones_l = 0;
		ones_r = 0;
		repeat (128) begin
			@(negedge clk_sys);
			if (audio_l)
				ones_l++;
			if (audio_r)
				ones_r++;
		end
		check_level("audio_l ones", 7'((ones_l > 127) ? 127 : ones_l), want);
		check_level("audio_r ones", 7'((ones_r > 127) ? 127 : ones_r), want);
	endtask

	// Extended arrow key held across a number of frame starts
	task automatic hold_arrow(input logic [7:0] code, input int frames);
		wait_vs_rise();
		ps2_send(SC_EXTEND, 1'b0);
		ps2_send(code, 1'b0);
		repeat (frames) wait_vs_rise();
		ps2_send(SC_EXTEND, 1'b0);
		ps2_send(SC_BREAK, 1'b0);
		ps2_send(code, 1'b0);
	endtask

	task automatic move_car(input logic right, input int frames);
		repeat (frames) begin
			if (right && exp_car_x < H_ACTIVE - CAR_W - 1)
				exp_car_x++;
			else if (!right && exp_car_x > 1)
				exp_car_x--;
		end
	endtask

	initial begin
		int frames;
		rst_n        = 1'b0;
		ps2_kbd_clk  = 1'b1;
		ps2_kbd_data = 1'b1;
		scan_mode    = SCAN_NONE;
		test_mode    = 1'b0;
		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		check_bit("led", led, 1'b1);
		check_audio(7'd0);
		wait_vs_rise();
		wait_vs_rise();
		@(negedge clk_sys);
		check_level("vga_hs pulses per frame", 7'(hs_per_frame), 7'(V_TOTAL));
		check_frame();

		wait_vs_rise();
		ps2_send(SC_START, 1'b0);
		ps2_send(SC_BREAK, 1'b0);
		ps2_send(SC_START, 1'b0);
		wait_vs_rise();
		check_bit("led", led, 1'b0);
		ps2_send(SC_GAS, 1'b0);
		repeat (8) @(negedge clk_sys);
		check_audio(ENGINE_GAS);
		ps2_send(SC_BREAK, 1'b0);
		ps2_send(SC_GAS, 1'b0);
		repeat (8) @(negedge clk_sys);
		check_audio(ENGINE_IDLE);

		frames = 1 + ($unsigned($random(seed)) % 10);
		hold_arrow(SC_RIGHT, frames);
		move_car(1'b1, frames);
		check_frame();
		frames = 1 + ($unsigned($random(seed)) % 10);
		hold_arrow(SC_LEFT, frames);
		move_car(1'b0, frames);
		check_frame();

		wait_vs_rise();
		ps2_send(SC_EXTEND, 1'b0);
		ps2_send(SC_RIGHT, 1'b1); // Corrupted frame must be dropped
		check_frame();

		scan_mode = SCAN_25;
		check_frame();
		scan_mode = SCAN_50;
		check_frame();
		scan_mode = SCAN_NONE;
		test_mode = 1'b1;
		check_frame();

		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
